// ==== common/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Architectural registers seen by the instruction set
`define AREGS 8

// Physical registers behind the rename map
`define PREGS 32

// Outstanding branch checkpoints, a power of two so the ring pointers wrap
`define NCHECK 4

// Credits held by the front end, equal to the request buffer depth
`define RN_CREDITS 2

`endif

// ==== common/rename_pkg.sv ====
`include "rename_cfg.svh"

package rename_pkg;

   // ====================
   // Register numbers
   // ====================
   typedef logic [$clog2(`AREGS)-1:0] areg_t;   // Architectural register number
   typedef logic [$clog2(`PREGS)-1:0] preg_t;   // Physical register number

   // Index of a slot in the checkpoint ring
   typedef logic [$clog2(`NCHECK)-1:0] ckpt_t;

   // ====================
   // Rename state
   // ====================
   typedef logic [`PREGS-1:0] avail_t;          // Bit i set when physical register i is free
   typedef preg_t [`AREGS-1:0] map_t;           // Entry i holds the mapping of areg i

   // One snapshot as held in the checkpoint RAM
   typedef struct packed {
      map_t   map;     // Map table after the branch renamed
      avail_t avail;   // Free bitmap after the branch renamed
   } checkpoint_t;

endpackage

// ==== common/rename_if.sv ====
// Map table access: lookup of the head request, update and restore
interface map_if;
   import rename_pkg::*;

   areg_t src;           // Source areg of the request being renamed
   areg_t dst;           // Destination areg, also the update address
   preg_t src_preg;      // Current mapping of src
   preg_t old_preg;      // Current mapping of dst, freed later at commit
   logic  upd_en;        // Write upd_preg into the dst entry
   preg_t upd_preg;
   map_t  state;         // Whole map for the snapshot
   logic  restore_en;    // Load restore_map on a mispredict
   map_t  restore_map;

   modport ctrl (output src, dst, upd_en, upd_preg, restore_en, restore_map,
                 input  src_preg, old_preg, state);
   modport dp   (input  src, dst, upd_en, upd_preg, restore_en, restore_map,
                 output src_preg, old_preg, state);
endinterface

// Free list access: allocation and restore
interface alloc_if;
   import rename_pkg::*;

   logic   grant;          // Take the offered register this cycle
   preg_t  preg;           // Lowest free register on offer
   logic   empty;          // No register free, preg is not valid
   avail_t state;          // Whole bitmap for the snapshot
   logic   restore_en;
   avail_t restore_avail;  // Snapshot bitmap, merged with the live one

   modport ctrl (output grant, restore_en, restore_avail,
                 input  preg, empty, state);
   modport dp   (input  grant, restore_en, restore_avail,
                 output preg, empty, state);
endinterface

// Checkpoint RAM access, write side and restore read side
interface ckpt_if;
   import rename_pkg::*;

   logic        we;        // Write request, delayed one cycle in the RAM
   ckpt_t       widx;
   checkpoint_t wdata;
   ckpt_t       ridx;      // Slot read for a restore
   checkpoint_t rdata;     // Combinational read data

   modport ctrl (output we, widx, wdata, ridx, input rdata);
   modport mem  (input  we, widx, wdata, ridx, output rdata);
endinterface

// ==== checkpoint/checkpoint_ram.sv ====
`include "rename_cfg.svh"

module checkpoint_ram (
   input logic clka,
   input logic rst,
   ckpt_if.mem ckpt
);
   import rename_pkg::*;

   checkpoint_t mem [`NCHECK];   // Small enough for distributed RAM

   logic        we_q;            // Write port delayed by one clock
   ckpt_t       widx_q;
   checkpoint_t wdata_q;

   // The write lands one edge after it is requested, so a read of the
   // same slot in the request cycle still returns the old snapshot
   always_ff @(posedge clka) begin
      if (rst) begin
         we_q <= 1'b0;
      end else begin
         we_q <= ckpt.we;
      end
   end

   always_ff @(posedge clka) begin
      widx_q  <= ckpt.widx;
      wdata_q <= ckpt.wdata;
   end

   always_ff @(posedge clka) begin
      if (we_q) begin
         mem[widx_q] <= wdata_q;
      end
   end

   assign ckpt.rdata = mem[ckpt.ridx];   // Restore read, no clock in the path

endmodule

// ==== logic/map_table.sv ====
`include "rename_cfg.svh"

module map_table (
   input logic clka,
   input logic rst,
   map_if.dp   map
);
   import rename_pkg::*;

   map_t map_q;   // Live architectural to physical mapping

   // ====================
   // Lookup
   // ====================
   // Both reads see the map before this cycle's update, so an instruction
   // that reads and writes the same areg gets the older producer
   assign map.src_preg = map_q[map.src];
   assign map.old_preg = map_q[map.dst];
   assign map.state    = map_q;          // Snapshot source for the checkpoint RAM

   // ====================
   // Update and restore
   // ====================
   always_ff @(posedge clka) begin
      if (rst) begin
         for (int i = 0; i < `AREGS; i++) begin
            map_q[i] <= preg_t'(i);      // Identity mapping out of reset
         end
      end else if (map.restore_en) begin
         map_q <= map.restore_map;       // Whole map back to the branch point
      end else if (map.upd_en) begin
         map_q[map.dst] <= map.upd_preg;
      end
   end

endmodule

// ==== logic/free_list.sv ====
`include "rename_cfg.svh"

module free_list (
   input logic              clka,
   input logic              rst,
   alloc_if.dp              alloc,
   input logic              commit_valid,
   input rename_pkg::preg_t commit_preg
);
   import rename_pkg::*;

   avail_t avail_q;   // Bit set while the register is free
   avail_t avail_d;
   preg_t  lowest;    // Lowest set bit of avail_q

   // ====================
   // Allocator
   // ====================
   // Scan from the top down so the last hit is the lowest free register
   always_comb begin
      lowest = '0;
      for (int i = `PREGS - 1; i >= 0; i--) begin
         if (avail_q[i]) begin
            lowest = preg_t'(i);
         end
      end
   end

   assign alloc.preg  = lowest;
   assign alloc.empty = ~|avail_q;   // preg is meaningless when set
   assign alloc.state = avail_q;

   // ====================
   // Bitmap update
   // ====================
   always_comb begin
      avail_d = avail_q;
      if (alloc.grant) begin
         avail_d[lowest] = 1'b0;
      end
      // Registers taken after the checkpoint come back, registers freed
      // since the checkpoint stay free
      if (alloc.restore_en) begin
         avail_d = avail_d | alloc.restore_avail;
      end
      if (commit_valid) begin
         avail_d[commit_preg] = 1'b1;   // Applies in a restore cycle too
      end
   end

   always_ff @(posedge clka) begin
      if (rst) begin
         avail_q <= {{(`PREGS - `AREGS){1'b1}}, {`AREGS{1'b0}}};   // Low regs hold the identity map
      end else begin
         avail_q <= avail_d;
      end
   end

endmodule

// ==== logic/rename_ctrl.sv ====
`include "rename_cfg.svh"

module rename_ctrl (
   input  logic              clka,
   input  logic              rst,
   input  logic              req_valid,
   input  rename_pkg::areg_t req_src,
   input  rename_pkg::areg_t req_dst,
   input  logic              req_branch,
   input  logic              resolve_valid,
   input  logic              resolve_mispredict,
   output logic              crd_ret,
   output logic              out_valid,
   output rename_pkg::preg_t out_src_preg,
   output rename_pkg::preg_t out_dst_preg,
   output rename_pkg::preg_t out_old_preg,
   output rename_pkg::ckpt_t out_ckpt,
   map_if.ctrl               map,
   alloc_if.ctrl             alloc,
   ckpt_if.ctrl              ckpt
);
   import rename_pkg::*;

   localparam int QW  = (`RN_CREDITS > 1) ? $clog2(`RN_CREDITS) : 1;   // Buffer pointer
   localparam int CW  = $clog2(`RN_CREDITS + 1);                       // Buffer occupancy
   localparam int KW  = $clog2(`NCHECK + 1);                           // Ring occupancy

   typedef enum logic {run, flush} flush_state_t;

   areg_t           buf_src [`RN_CREDITS];
   areg_t           buf_dst [`RN_CREDITS];
   logic            buf_branch [`RN_CREDITS];
   logic [QW-1:0]   rd_ptr;
   logic [QW-1:0]   wr_ptr;
   logic [CW-1:0]   buf_cnt;
   logic [CW-1:0]   drop_cnt;        // Credits still owed after a flush
   flush_state_t    state;
   ckpt_t           ckpt_head;       // Oldest outstanding branch
   ckpt_t           ckpt_tail;       // Next free slot
   logic [KW-1:0]   ckpt_cnt;
   logic            ckpt_pend;       // Snapshot write due this cycle
   ckpt_t           ckpt_widx;
   logic            mispredict;
   logic            resolve_ok;
   logic            take;
   logic            take_branch;

   function automatic logic [QW-1:0] next_ptr(input logic [QW-1:0] p);
      return (p == QW'(`RN_CREDITS - 1)) ? '0 : p + 1'b1;
   endfunction

   // ====================
   // Rename decision
   // ====================
   assign mispredict  = resolve_valid & resolve_mispredict;
   assign resolve_ok  = resolve_valid & ~resolve_mispredict;
   // No rename in a restore cycle, the map and bitmap are being reloaded
   assign take        = (state == run) && (buf_cnt != '0) && !mispredict && !alloc.empty &&
                        (!buf_branch[rd_ptr] || (ckpt_cnt != KW'(`NCHECK)));
   assign take_branch = take & buf_branch[rd_ptr];
   assign crd_ret     = take | (state == flush);   // One credit per rename or dropped request

   assign map.src      = buf_src[rd_ptr];
   assign map.dst      = buf_dst[rd_ptr];
   assign map.upd_en   = take;
   assign map.upd_preg = alloc.preg;
   assign alloc.grant  = take;

   // Restore always comes from the oldest branch
   assign ckpt.ridx           = ckpt_head;
   assign map.restore_en      = mispredict;
   assign map.restore_map     = ckpt.rdata.map;
   assign alloc.restore_en    = mispredict;
   assign alloc.restore_avail = ckpt.rdata.avail;

   // Live state one cycle after the branch edge already includes its rename
   assign ckpt.we    = ckpt_pend;
   assign ckpt.widx  = ckpt_widx;
   assign ckpt.wdata = {map.state, alloc.state};

   // ====================
   // Request buffer
   // ====================
   always_ff @(posedge clka) begin
      if (req_valid) begin
         buf_src[wr_ptr]    <= req_src;
         buf_dst[wr_ptr]    <= req_dst;
         buf_branch[wr_ptr] <= req_branch;
      end
   end

   always_ff @(posedge clka) begin
      if (rst) begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         buf_cnt  <= '0;
         drop_cnt <= '0;
         state    <= run;
      end else begin
         if (req_valid) wr_ptr <= next_ptr(wr_ptr);
         if (mispredict) begin
            rd_ptr  <= wr_ptr;                  // Drop everything buffered so far
            buf_cnt <= CW'(req_valid);          // A request in this cycle survives
         end else begin
            if (take) rd_ptr <= next_ptr(rd_ptr);
            buf_cnt <= buf_cnt + CW'(req_valid) - CW'(take);
         end
         case (state)
            run: begin
               if (mispredict && (buf_cnt != '0)) begin
                  drop_cnt <= buf_cnt;
                  state    <= flush;
               end
            end
            flush: begin
               drop_cnt <= drop_cnt - 1'b1;
               if (drop_cnt == CW'(1)) state <= run;
            end
            default: state <= run;
         endcase
      end
   end

   // ====================
   // Checkpoint ring
   // ====================
   always_ff @(posedge clka) begin
      if (rst) begin
         ckpt_head <= '0;
         ckpt_tail <= '0;
         ckpt_cnt  <= '0;
         ckpt_pend <= 1'b0;
         ckpt_widx <= '0;
      end else begin
         ckpt_pend <= take_branch;
         ckpt_widx <= ckpt_tail;
         if (mispredict) begin
            ckpt_head <= ckpt_tail;   // Restored slot and all younger ones go
            ckpt_cnt  <= '0;
         end else begin
            if (take_branch) ckpt_tail <= ckpt_tail + 1'b1;
            if (resolve_ok)  ckpt_head <= ckpt_head + 1'b1;
            ckpt_cnt <= ckpt_cnt + KW'(take_branch) - KW'(resolve_ok);
         end
      end
   end

   // ====================
   // Result register
   // ====================
   always_ff @(posedge clka) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= take;
      end
   end

   always_ff @(posedge clka) begin
      if (take) begin
         out_src_preg <= map.src_preg;
         out_dst_preg <= alloc.preg;
         out_old_preg <= map.old_preg;                         // Freed when this one commits
         out_ckpt     <= buf_branch[rd_ptr] ? ckpt_tail : '0;  // Meaningful for branches only
      end
   end

endmodule

// ==== logic/rename_top.sv ====
module rename_top (
   input  logic              clka,
   input  logic              rst,
   input  logic              req_valid,
   input  rename_pkg::areg_t req_src,
   input  rename_pkg::areg_t req_dst,
   input  logic              req_branch,
   input  logic              commit_valid,
   input  rename_pkg::preg_t commit_preg,
   input  logic              resolve_valid,
   input  logic              resolve_mispredict,
   output logic              crd_ret,
   output logic              out_valid,
   output rename_pkg::preg_t out_src_preg,
   output rename_pkg::preg_t out_dst_preg,
   output rename_pkg::preg_t out_old_preg,
   output rename_pkg::ckpt_t out_ckpt
);

   map_if   map_bus ();     // Control to map table
   alloc_if alloc_bus ();   // Control to free list
   ckpt_if  ckpt_bus ();    // Control to checkpoint RAM

   rename_ctrl u_ctrl (
      .clka               (clka),
      .rst                (rst),
      .req_valid          (req_valid),
      .req_src            (req_src),
      .req_dst            (req_dst),
      .req_branch         (req_branch),
      .resolve_valid      (resolve_valid),
      .resolve_mispredict (resolve_mispredict),
      .crd_ret            (crd_ret),
      .out_valid          (out_valid),
      .out_src_preg       (out_src_preg),
      .out_dst_preg       (out_dst_preg),
      .out_old_preg       (out_old_preg),
      .out_ckpt           (out_ckpt),
      .map                (map_bus.ctrl),
      .alloc              (alloc_bus.ctrl),
      .ckpt               (ckpt_bus.ctrl)
   );

   map_table u_map (
      .clka (clka),
      .rst  (rst),
      .map  (map_bus.dp)
   );

   // Commits go straight to the free list, the control path never sees them
   free_list u_free (
      .clka         (clka),
      .rst          (rst),
      .alloc        (alloc_bus.dp),
      .commit_valid (commit_valid),
      .commit_preg  (commit_preg)
   );

   checkpoint_ram u_ckpt (
      .clka (clka),
      .rst  (rst),
      .ckpt (ckpt_bus.mem)
   );

endmodule

// ==== verification/rename_checker.sv ====
`include "rename_cfg.svh"

module rename_checker (
   input  logic              clka,
   input  logic              rst,
   input  logic              req_valid,
   input  rename_pkg::areg_t req_src,
   input  rename_pkg::areg_t req_dst,
   input  logic              req_branch,
   input  rename_pkg::preg_t req_exp,
   input  int                req_num,
   input  logic              commit_valid,
   input  rename_pkg::preg_t commit_preg,
   input  logic              resolve_valid,
   input  logic              resolve_mispredict,
   input  logic              crd_ret,
   input  logic              out_valid,
   input  rename_pkg::preg_t out_src_preg,
   input  rename_pkg::preg_t out_dst_preg,
   input  rename_pkg::preg_t out_old_preg,
   input  rename_pkg::ckpt_t out_ckpt,
   output int                errors,
   output int                pending
);
   timeunit 1ns;
   timeprecision 100ps;
   import rename_pkg::*;

   typedef struct packed {
      int    num;
      areg_t src;
      areg_t dst;
      logic  br;
      preg_t exp;
   } req_rec_t;

   // The model trails the DUT by one edge so a result seen at an edge
   // belongs to the rename taken at the edge before
   map_t        m_map;
   avail_t      m_avail;
   checkpoint_t ring [`NCHECK];
   ckpt_t       head;                // Oldest outstanding branch
   ckpt_t       tail;
   int          ring_cnt;
   logic        snap_due;
   req_rec_t    waiting [$];         // Sent but neither renamed nor dropped
   req_rec_t    last_req;            // Inputs sampled at the previous edge
   logic        last_req_valid;
   logic        last_commit;
   preg_t       last_commit_preg;
   logic        last_resolve;
   logic        last_mispredict;
   int          sent;
   int          returned;

   task automatic check_value(input string name, input int exp, input int act);
      if (exp != act) begin
         $display("error %s: expected %0d, actual %0d", name, exp, act);
         errors++;
      end
   endtask

   task automatic reset_model();
      for (int i = 0; i < `AREGS; i++) begin
         m_map[i] = preg_t'(i);
      end
      for (int i = 0; i < `PREGS; i++) begin
         m_avail[i] = (i >= `AREGS);     // Low registers back the identity map
      end
      head     = '0;
      tail     = '0;
      ring_cnt = 0;
      waiting.delete();
      last_req_valid = 1'b0;
      last_commit    = 1'b0;
      last_resolve   = 1'b0;
      sent     = 0;
      returned = 0;
      errors   = 0;
      pending  = 0;
   endtask

   // ====================
   // Rename result
   // ====================
   task automatic check_rename();
      req_rec_t r;
      preg_t    lowest;
      logic     any_free;
      if (waiting.size() == 0) begin
         $display("a rename result came out with no request waiting");
         errors++;
         return;
      end
      r = waiting.pop_front();
      any_free = 1'b0;
      lowest   = '0;
      for (int i = 0; (i < `PREGS) && !any_free; i++) begin
         if (m_avail[i]) begin
            lowest   = preg_t'(i);
            any_free = 1'b1;
         end
      end
      if (!any_free) begin
         $display("rename %0d finished although no physical register was free", r.num);
         errors++;
      end
      if (r.br && (ring_cnt == `NCHECK)) begin
         $display("branch %0d renamed while every checkpoint slot was in use", r.num);
         errors++;
      end
      check_value($sformatf("rename %0d src", r.num), int'(m_map[r.src]), int'(out_src_preg));
      check_value($sformatf("rename %0d old", r.num), int'(m_map[r.dst]), int'(out_old_preg));
      check_value($sformatf("rename %0d dst", r.num), int'(lowest), int'(out_dst_preg));
      check_value($sformatf("rename %0d file dst", r.num), int'(r.exp), int'(out_dst_preg));
      if (r.br) begin
         check_value($sformatf("rename %0d ckpt", r.num), int'(tail), int'(out_ckpt));
      end
      m_map[r.dst]    = lowest;
      m_avail[lowest] = 1'b0;
      snap_due        = r.br;   // Snapshot waits for the commit of the same edge
   endtask

   task automatic resolve(input logic mis);
      if (ring_cnt == 0) begin
         $display("a branch resolved with no checkpoint outstanding");
         errors++;
      end else if (mis) begin
         m_map    = ring[head].map;
         m_avail  = m_avail | ring[head].avail;   // Later frees stay free
         head     = tail;
         ring_cnt = 0;
         waiting.delete();                        // Buffered wrong-path requests go
      end else begin
         head = head + 1'b1;
         ring_cnt--;
      end
   endtask

   // ====================
   // Model update
   // ====================
   always @(posedge clka) begin
      if (rst) begin
         reset_model();
      end else begin
         snap_due = 1'b0;
         if (out_valid) check_rename();
         if (last_commit) m_avail[last_commit_preg] = 1'b1;
         if (snap_due) begin
            ring[tail].map   = m_map;
            ring[tail].avail = m_avail;
            tail = tail + 1'b1;
            ring_cnt++;
         end
         if (last_resolve) resolve(last_mispredict);
         if (last_req_valid) waiting.push_back(last_req);   // Could not rename yet
         if (req_valid) sent++;
         if (crd_ret) returned++;
         if (returned > sent) begin
            $display("a credit came back with no request outstanding");
            errors++;
         end
         last_req_valid   = req_valid;
         last_req.num     = req_num;
         last_req.src     = req_src;
         last_req.dst     = req_dst;
         last_req.br      = req_branch;
         last_req.exp     = req_exp;
         last_commit      = commit_valid;
         last_commit_preg = commit_preg;
         last_resolve     = resolve_valid;
         last_mispredict  = resolve_mispredict;
         pending = waiting.size() + int'(last_req_valid);
      end
   end

endmodule

// ==== verification/rename_tb.sv ====
`include "rename_cfg.svh"

module rename_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import rename_pkg::*;

   localparam int TIMEOUT = 200;   // Cycles that any single wait may take

   logic  clka;
   logic  rst;
   logic  req_valid;
   areg_t req_src;
   areg_t req_dst;
   logic  req_branch;
   preg_t req_exp;        // Destination expected by the stimulus file for the checker
   int    req_num;        // Running request number that names the test in error lines
   logic  commit_valid;
   preg_t commit_preg;
   logic  resolve_valid;
   logic  resolve_mispredict;
   logic  crd_ret;
   logic  out_valid;
   preg_t out_src_preg;
   preg_t out_dst_preg;
   preg_t out_old_preg;
   ckpt_t out_ckpt;
   int    errors;         // Mismatches counted by the checker
   int    pending;        // Requests the checker still waits on
   int    sent;           // Credits spent by the driver
   int    crd_seen;       // Credits handed back by the DUT
   int    timeouts;
   int    tb_errors;

   rename_top dut0 (.*);

   rename_checker chk0 (.*);

   always #2 clka = ~clka;   // 4 ns period

   always @(posedge clka) begin
      if (rst) begin
         crd_seen <= 0;
      end else if (crd_ret) begin
         crd_seen <= crd_seen + 1;
      end
   end

   // ====================
   // Driver tasks
   // ====================
   // Holds the driver at falling edges until the upstream owns a credit again
   task automatic wait_credit();
      int n;
      n = 0;
      while ((sent - crd_seen >= `RN_CREDITS) && (n < TIMEOUT)) begin
         @(negedge clka);
         n++;
      end
      if (sent - crd_seen >= `RN_CREDITS) begin
         $display("timeout while waiting for the DUT to return a credit");
         timeouts++;
      end
   endtask

   task automatic send_rename(input int src, input int dst, input int br, input int exp);
      wait_credit();
      if (timeouts == 0) begin
         req_num++;
         req_valid  = 1'b1;   // One-cycle pulse spends the credit
         req_src    = areg_t'(src);
         req_dst    = areg_t'(dst);
         req_branch = (br != 0);
         req_exp    = preg_t'(exp);
         sent++;
         @(negedge clka);
         req_valid = 1'b0;
      end
   endtask

   task automatic pulse_commit(input int preg);
      commit_valid = 1'b1;
      commit_preg  = preg_t'(preg);
      @(negedge clka);
      commit_valid = 1'b0;
   endtask

   // Resolves always name the oldest outstanding branch
   task automatic pulse_resolve(input logic mis);
      resolve_valid      = 1'b1;
      resolve_mispredict = mis;
      @(negedge clka);
      resolve_valid      = 1'b0;
      resolve_mispredict = 1'b0;
   endtask

   // All credits back and no result still owed
   task automatic wait_idle();
      int n;
      n = 0;
      while (((sent != crd_seen) || (pending != 0)) && (n < TIMEOUT)) begin
         @(negedge clka);
         n++;
      end
      if ((sent != crd_seen) || (pending != 0)) begin
         $display("timeout with requests still outstanding at the end of the stimulus");
         timeouts++;
      end
   endtask

   // ====================
   // Stimulus
   // ====================
   initial begin
      string line;
      byte   kind;
      int    a;
      int    b;
      int    c;
      int    d;
      int    fd;
      clka = 1'b0;
      rst  = 1'b1;
      req_valid          = 1'b0;
      req_src            = '0;
      req_dst            = '0;
      req_branch         = 1'b0;
      req_exp            = '0;
      req_num            = 0;
      commit_valid       = 1'b0;
      commit_preg        = '0;
      resolve_valid      = 1'b0;
      resolve_mispredict = 1'b0;
      sent      = 0;
      timeouts  = 0;
      tb_errors = 0;
      repeat (8) @(negedge clka);
      rst = 1'b0;
      fd = $fopen("verification/rename_input.txt", "r");
      if (fd == 0) begin
         $display("the stimulus file could not be opened");
         tb_errors++;
      end else begin
         while ((timeouts == 0) && ($fgets(line, fd) != 0)) begin
            kind = 0;
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            void'($sscanf(line, "%c %d %d %d %d", kind, a, b, c, d));
            case (kind)
               "R": send_rename(a, b, c, d);
               "C": pulse_commit(a);
               "B": pulse_resolve(1'b0);
               "M": pulse_resolve(1'b1);
               "W": repeat (a) @(negedge clka);   // Idle cycles
               default: ;                          // Comment or blank line
            endcase
         end
         $fclose(fd);
         if (timeouts == 0) begin
            wait_idle();
         end
      end
      repeat (2) @(negedge clka);
      $display("checker errors %0d, testbench errors %0d, timeouts %0d",
               errors, tb_errors, timeouts);
      if ((errors == 0) && (tb_errors == 0) && (timeouts == 0)) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== verification/rename_input.txt ====
# R src dst branch expected_dst | C preg | B (resolve) | M (mispredict) | W idle_cycles
# Renames after reset count up from 8, a committed register comes back first
R 0 1 0 8
R 1 2 0 9
R 2 3 0 10
R 3 4 0 11
C 1
R 4 5 0 1
# Branch, two younger renames and a commit, then a mispredict
R 1 6 1 12
R 6 1 0 13
R 2 2 0 14
C 2
W 4
M
R 0 1 0 2
R 0 2 0 13
# Fill all checkpoint slots, the fifth branch waits for a resolve
R 3 3 1 14
R 3 4 1 15
R 4 5 1 16
R 5 6 1 17
R 6 7 1 18
W 6
B
W 3
# This branch stalls and is dropped by the mispredict
R 7 0 1 19
W 3
M
# Use up every free register, the last rename waits for a commit
R 5 0 0 16
R 1 1 0 17
R 2 2 0 18
R 3 3 0 19
R 4 4 0 20
R 5 5 0 21
R 6 6 0 22
R 7 7 0 23
R 0 1 0 24
R 1 2 0 25
R 2 3 0 26
R 3 4 0 27
R 4 5 0 28
R 5 6 0 29
R 6 7 0 30
R 7 0 0 31
R 0 1 0 4
W 6
C 4

// ==== rename.f ====
+incdir+common
common/rename_pkg.sv
common/rename_if.sv
checkpoint/checkpoint_ram.sv
logic/map_table.sv
logic/free_list.sv
logic/rename_ctrl.sv
logic/rename_top.sv
verification/rename_checker.sv
verification/rename_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f rename.f --top-module rename_tb -o rename_sim \
   > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rename_sim > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
